// File: bench/mac_column_tb.sv
/* Directed and random tests of the MAC column against a dot product model.
   Results must come out strictly in the order the executes were accepted */
`timescale 1ns/1ns
`include "mac_column_consts.svh"

module mac_column_tb;

        typedef mac_data_pkg::act_t [2*`MAC_ROWS-1:0] op_data_t;

        localparam int RESET_CYCLES = 8;
        localparam int OP_CYCLES    = 2 * `MAC_ROWS + 20;
        localparam int RANDOM_OPS   = 30;
        // Idle check, load and execute, reload, back-pressure, random mix, final check
        localparam int NUM_OPS      = 1 + 3 + 5 + (`MAC_DRAIN_DEPTH + 2) + RANDOM_OPS + 1;

        logic                clk;
        logic                reset;
        logic                in_req;
        mac_ctrl_pkg::op_t   in_op;
        op_data_t            in_data;
        logic                out_ack;
        logic                in_ack;
        logic                out_req;
        mac_data_pkg::psum_t out_data;

        // Weights as the model believes them, in the same layout as in_data
        mac_data_pkg::act_t  weights [2*`MAC_ROWS];
        mac_data_pkg::psum_t exp_q [$];

        int   mismatches;
        int   other_errors;
        int   exec_acks;
        int   results_taken;
        int   sink_max;
        logic sink_hold;
        logic sink_busy;

        mac_column dut_i (
                .clk      (clk),
                .reset    (reset),
                .in_req   (in_req),
                .in_op    (in_op),
                .in_data  (in_data),
                .out_ack  (out_ack),
                .in_ack   (in_ack),
                .out_req  (out_req),
                .out_data (out_data)
        );

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        // Sum over all rows of a0*w0 + a1*w1, wrapping at the psum width
        function automatic mac_data_pkg::psum_t dot_product(input op_data_t a);
                mac_data_pkg::psum_t sum;
                sum = '0;
                for (int i = 0; i < 2 * `MAC_ROWS; i++) begin
                        sum = sum + mac_data_pkg::psum_t'(a[i]) *
                                    mac_data_pkg::psum_t'(weights[i]);
                end
                return sum;
        endfunction

        function automatic op_data_t pattern_data(input int base, input int step);
                op_data_t d;
                for (int i = 0; i < 2 * `MAC_ROWS; i++) begin
                        d[i] = mac_data_pkg::act_t'(base + step * i);
                end
                return d;
        endfunction

        function automatic op_data_t random_data();
                op_data_t d;
                for (int i = 0; i < 2 * `MAC_ROWS; i++) begin
                        d[i] = mac_data_pkg::act_t'($urandom_range(15, 0));
                end
                return d;
        endfunction

        // Four-phase input handshake, the model follows once in_ack is seen
        task automatic send_op(input mac_ctrl_pkg::op_t op, input op_data_t data);
                @(negedge clk);
                in_op   = op;
                in_data = data;
                in_req  = 1'b1;
                @(negedge clk);
                while (!in_ack) begin
                        @(negedge clk);
                end
                if (op == mac_ctrl_pkg::op_load) begin
                        for (int i = 0; i < 2 * `MAC_ROWS; i++) begin
                                weights[i] = data[i];
                        end
                end else begin
                        exp_q.push_back(dot_product(data));
                        exec_acks++;
                end
                in_req = 1'b0;
                @(negedge clk);
                while (in_ack) begin
                        @(negedge clk);
                end
        endtask

        task automatic wait_drained();
                while (exp_q.size() != 0 || sink_busy) begin
                        @(negedge clk);
                end
        endtask

        // Output handshake with a random delay of up to sink_max cycles before out_ack
        initial begin : sink
                mac_data_pkg::psum_t expected;
                forever begin
                        @(negedge clk);
                        if (out_req && !sink_hold) begin
                                sink_busy = 1'b1;
                                if (exp_q.size() == 0) begin
                                        $display("Result %0d at %0t with no execute outstanding",
                                                 out_data, $time);
                                        other_errors++;
                                end else begin
                                        expected = exp_q.pop_front();
                                        if (out_data !== expected) begin
                                                $display("mismatch at %0t: expected %0d got %0d",
                                                         $time, expected, out_data);
                                                mismatches++;
                                        end
                                end
                                repeat ($urandom_range(sink_max, 0)) @(negedge clk);
                                out_ack = 1'b1;
                                while (out_req) begin
                                        @(negedge clk);
                                end
                                out_ack = 1'b0;
                                results_taken++;
                                sink_busy = 1'b0;
                        end
                end
        end

        task automatic check_idle();
                repeat (10) begin
                        @(negedge clk);
                        if (in_ack || out_req) begin
                                $display("mismatch at %0t: in_ack %b out_req %b with no request",
                                         $time, in_ack, out_req);
                                mismatches++;
                        end
                end
        endtask

        task automatic check_load_execute();
                send_op(mac_ctrl_pkg::op_load, pattern_data(1, 2));
                send_op(mac_ctrl_pkg::op_execute, pattern_data(3, 1));
                send_op(mac_ctrl_pkg::op_execute, pattern_data(15, 7));
                wait_drained();
        endtask

        // A slow sink keeps the older results in the drain while the reload happens
        task automatic check_reload();
                sink_max = 8;
                send_op(mac_ctrl_pkg::op_execute, pattern_data(2, 3));
                send_op(mac_ctrl_pkg::op_execute, pattern_data(9, 5));
                send_op(mac_ctrl_pkg::op_load, pattern_data(14, 11));
                send_op(mac_ctrl_pkg::op_execute, pattern_data(2, 3));
                send_op(mac_ctrl_pkg::op_execute, pattern_data(7, 13));
                wait_drained();
                sink_max = 0;
        endtask

        task automatic check_back_pressure();
                int base;
                base      = exec_acks;
                sink_hold = 1'b1;
                fork
                        for (int j = 0; j < `MAC_DRAIN_DEPTH + 2; j++) begin
                                send_op(mac_ctrl_pkg::op_execute, pattern_data(j, j + 1));
                        end
                join_none
                while (exec_acks - base < `MAC_DRAIN_DEPTH) begin
                        @(negedge clk);
                end
                repeat (3 * (2 * `MAC_ROWS + 2)) @(negedge clk);
                if (exec_acks - base > `MAC_DRAIN_DEPTH) begin
                        $display("%0d executes were accepted while no result was taken",
                                 exec_acks - base);
                        other_errors++;
                end
                sink_hold = 1'b0;
                wait fork;
                wait_drained();
        endtask

        task automatic check_random_mix();
                sink_max = 5;
                for (int n = 0; n < RANDOM_OPS; n++) begin
                        if ($urandom_range(4, 0) == 0) begin
                                send_op(mac_ctrl_pkg::op_load, random_data());
                        end else begin
                                send_op(mac_ctrl_pkg::op_execute, random_data());
                        end
                end
                wait_drained();
                sink_max = 0;
        endtask

        initial begin : watchdog
                repeat (RESET_CYCLES + NUM_OPS * OP_CYCLES) @(posedge clk);
                $display("Timeout after %0d cycles, the tests did not finish",
                         RESET_CYCLES + NUM_OPS * OP_CYCLES);
                $display("Simulation failed");
                $finish;
        end

        initial begin
                void'($urandom(80));
                reset         = 1'b1;
                in_req        = 1'b0;
                in_op         = mac_ctrl_pkg::op_load;
                in_data       = '0;
                out_ack       = 1'b0;
                sink_hold     = 1'b0;
                sink_busy     = 1'b0;
                sink_max      = 0;
                mismatches    = 0;
                other_errors  = 0;
                exec_acks     = 0;
                results_taken = 0;
                for (int i = 0; i < 2 * `MAC_ROWS; i++) begin
                        weights[i] = '0;
                end
                repeat (RESET_CYCLES) @(negedge clk);
                reset = 1'b0;

                check_idle();
                check_load_execute();
                check_reload();
                check_back_pressure();
                check_random_mix();

                // Anything arriving now would be a duplicate
                repeat (2 * `MAC_ROWS + 4) @(negedge clk);
                if (out_req) begin
                        $display("An extra result %0d appeared after all were taken", out_data);
                        other_errors++;
                end
                if (results_taken != exec_acks) begin
                        $display("%0d results were taken for %0d executes",
                                 results_taken, exec_acks);
                        other_errors++;
                end

                $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
                if (mismatches == 0 && other_errors == 0) begin
                        $display("Simulation completed successfully");
                end else begin
                        $display("Simulation failed");
                end
                $finish;
        end

endmodule

// File: mac_column.f
+incdir+.
verilog/mac_data_pkg.sv
verilog/mac_ctrl_pkg.sv
verilog/mac_tile.sv
verilog/act_feeder.sv
verilog/psum_drain.sv
verilog/mac_column.sv
bench/mac_column_tb.sv

// File: mac_column_consts.svh
/* Sizing for the MAC column. MAC_DRAIN_DEPTH also sets the feeder credits,
   so the drain FIFO cannot overflow as long as the two agree */
`ifndef MAC_COLUMN_CONSTS_SVH
`define MAC_COLUMN_CONSTS_SVH

// Width of one activation and of one kernel weight
`define MAC_ACT_BW 4

// Width of a partial sum, products and sums wrap at this width
`define MAC_PSUM_BW 16

// Number of tiles stacked in the column
`define MAC_ROWS 4

// Result slots in the drain FIFO
`define MAC_DRAIN_DEPTH 4

`endif

// File: verilog/act_feeder.sv
/* Accepts one operation per four-phase handshake and issues it skewed by 2 cycles per row.
   Executes need a drain credit, loads wait until the last execute has left the column */
`timescale 1ns/1ns
`include "mac_column_consts.svh"

module act_feeder (
        input  logic                                    clk,
        input  logic                                    reset,
        input  logic                                    in_req,
        input  mac_ctrl_pkg::op_t                       in_op,
        input  mac_data_pkg::act_t [2*`MAC_ROWS-1:0]    in_data,
        input  logic                                    slot_free,
        output logic                                    in_ack,
        output mac_data_pkg::act_t [`MAC_ROWS-1:0]      row_act,
        output mac_ctrl_pkg::inst_t [`MAC_ROWS-1:0]     row_inst
);

        localparam int CREDIT_BW   = $clog2(`MAC_DRAIN_DEPTH + 1);
        localparam int WAIT_CYCLES = 2 * `MAC_ROWS + 2;
        localparam int WAIT_BW     = $clog2(WAIT_CYCLES + 1);

        mac_ctrl_pkg::feed_state_t                  state;
        mac_ctrl_pkg::feed_state_t                  state_next;
        logic [CREDIT_BW-1:0]                       credits;
        logic [WAIT_BW-1:0]                         wait_cnt;
        logic                                       is_exec;
        logic                                       grant;
        logic                                       take;
        mac_ctrl_pkg::op_t                          op_q;
        mac_data_pkg::act_t [2*`MAC_ROWS-1:0]       data_q;
        logic                                       issue_first;
        logic                                       issue_second;
        mac_data_pkg::act_t [`MAC_ROWS-1:0]         launch_act;
        mac_ctrl_pkg::inst_t                        launch_inst;

        assign is_exec = (in_op == mac_ctrl_pkg::op_execute);
        assign grant   = is_exec ? (credits != '0) : (wait_cnt == '0);
        assign take    = ((state == mac_ctrl_pkg::feed_idle) ||
                          (state == mac_ctrl_pkg::feed_hold)) && in_req && grant;
        assign in_ack  = (state == mac_ctrl_pkg::feed_accept);

        always_comb begin
                state_next = state;
                case (state)
                        mac_ctrl_pkg::feed_idle,
                        mac_ctrl_pkg::feed_hold: begin
                                if (!in_req) begin
                                        state_next = mac_ctrl_pkg::feed_idle;
                                end else if (grant) begin
                                        state_next = mac_ctrl_pkg::feed_accept;
                                end else begin
                                        state_next = mac_ctrl_pkg::feed_hold;
                                end
                        end
                        mac_ctrl_pkg::feed_accept: begin
                                if (!in_req) begin
                                        state_next = mac_ctrl_pkg::feed_release;
                                end
                        end
                        default: begin
                                state_next = mac_ctrl_pkg::feed_idle;
                        end
                endcase
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        state        <= mac_ctrl_pkg::feed_idle;
                        credits      <= CREDIT_BW'(`MAC_DRAIN_DEPTH);
                        wait_cnt     <= '0;
                        issue_first  <= 1'b0;
                        issue_second <= 1'b0;
                end else begin
                        state        <= state_next;
                        issue_first  <= take;
                        issue_second <= issue_first;

                        // One credit per execute in flight or waiting in the drain
                        case ({take && is_exec, slot_free})
                                2'b10:   credits <= credits - 1'b1;
                                2'b01:   credits <= credits + 1'b1;
                                default: credits <= credits;
                        endcase

                        if (take && is_exec) begin
                                wait_cnt <= WAIT_BW'(WAIT_CYCLES);
                        end else if (wait_cnt != '0) begin
                                wait_cnt <= wait_cnt - 1'b1;
                        end
                end
        end

        // Operation is held here for its two issue cycles
        always_ff @(posedge clk) begin
                if (take) begin
                        op_q   <= in_op;
                        data_q <= in_data;
                end
        end

        always_comb begin
                for (int r = 0; r < `MAC_ROWS; r++) begin
                        launch_act[r] = issue_second ? data_q[2*r+1] : data_q[2*r];
                end
        end

        assign launch_inst.execute = (issue_first || issue_second) &&
                                     (op_q == mac_ctrl_pkg::op_execute);
        assign launch_inst.load    = (issue_first || issue_second) &&
                                     (op_q == mac_ctrl_pkg::op_load);

        // Row r sees the same issue 2r cycles later than row 0
        for (genvar r = 0; r < `MAC_ROWS; r++) begin : g_row
                if (r == 0) begin : g_direct
                        assign row_act[r]  = launch_act[r];
                        assign row_inst[r] = launch_inst;
                end else begin : g_skew
                        mac_data_pkg::act_t  dly_act  [2*r];
                        mac_ctrl_pkg::inst_t dly_inst [2*r];

                        always_ff @(posedge clk) begin
                                dly_act[0] <= launch_act[r];
                                for (int k = 1; k < 2 * r; k++) begin
                                        dly_act[k] <= dly_act[k-1];
                                end
                        end

                        always_ff @(posedge clk) begin
                                if (reset) begin
                                        for (int k = 0; k < 2 * r; k++) begin
                                                dly_inst[k] <= '0;
                                        end
                                end else begin
                                        dly_inst[0] <= launch_inst;
                                        for (int k = 1; k < 2 * r; k++) begin
                                                dly_inst[k] <= dly_inst[k-1];
                                        end
                                end
                        end

                        assign row_act[r]  = dly_act[2*r-1];
                        assign row_inst[r] = dly_inst[2*r-1];
                end
        end

endmodule

// File: verilog/mac_column.sv
/* One column of MAC_ROWS tiles with feeder and drain. Unsigned data,
   results are dot products over all rows modulo 2^MAC_PSUM_BW */
`timescale 1ns/1ns
`include "mac_column_consts.svh"

module mac_column (
        input  logic                                    clk,
        input  logic                                    reset,
        input  logic                                    in_req,
        input  mac_ctrl_pkg::op_t                       in_op,
        input  mac_data_pkg::act_t [2*`MAC_ROWS-1:0]    in_data,
        input  logic                                    out_ack,
        output logic                                    in_ack,
        output logic                                    out_req,
        output mac_data_pkg::psum_t                     out_data
);

        mac_data_pkg::act_t  [`MAC_ROWS-1:0]    row_act;
        mac_ctrl_pkg::inst_t [`MAC_ROWS-1:0]    row_inst;
        mac_data_pkg::psum_t [`MAC_ROWS:0]      psum_chain;
        logic                [`MAC_ROWS-1:0]    row_valid;
        logic                                   slot_free;

        act_feeder feeder_i (
                .clk       (clk),
                .reset     (reset),
                .in_req    (in_req),
                .in_op     (in_op),
                .in_data   (in_data),
                .slot_free (slot_free),
                .in_ack    (in_ack),
                .row_act   (row_act),
                .row_inst  (row_inst)
        );

        // Nothing enters from above the top row
        assign psum_chain[0] = '0;

        for (genvar r = 0; r < `MAC_ROWS; r++) begin : g_tile
                mac_tile tile_i (
                        .clk        (clk),
                        .reset      (reset),
                        .act        (row_act[r]),
                        .inst       (row_inst[r]),
                        .psum_n     (psum_chain[r]),
                        .psum_s     (psum_chain[r+1]),
                        .psum_valid (row_valid[r])
                );
        end

        // Only the bottom tile's valid marks a finished dot product
        psum_drain drain_i (
                .clk        (clk),
                .reset      (reset),
                .psum       (psum_chain[`MAC_ROWS]),
                .psum_valid (row_valid[`MAC_ROWS-1]),
                .out_ack    (out_ack),
                .out_req    (out_req),
                .out_data   (out_data),
                .slot_free  (slot_free)
        );

endmodule

// File: verilog/mac_ctrl_pkg.sv
/* Control encodings. The bit order of inst_t is execute over load */
`include "mac_column_consts.svh"

package mac_ctrl_pkg;

        // Per-row instruction that travels beside each activation
        typedef struct packed {
                logic execute;
                logic load;
        } inst_t;

        // Operation code on the input port
        typedef enum logic {
                op_load    = 1'b0,
                op_execute = 1'b1
        } op_t;

        // Input handshake states of the feeder
        // Hold means a request is waiting for credits or for the drain wait
        typedef enum logic [1:0] {
                feed_idle,
                feed_accept,
                feed_release,
                feed_hold
        } feed_state_t;

endpackage

// File: verilog/mac_data_pkg.sv
/* Data types of the column. All values are unsigned */
`include "mac_column_consts.svh"

package mac_data_pkg;

        // One activation or one kernel weight
        typedef logic [`MAC_ACT_BW-1:0] act_t;

        // Partial sum as it travels from north to south
        typedef logic [`MAC_PSUM_BW-1:0] psum_t;

endpackage

// File: verilog/mac_tile.sv
/* One weight-stationary tile. Loads and executes always come as pairs of
   cycles, and the result is valid for one cycle after the second execute */
`timescale 1ns/1ns
`include "mac_column_consts.svh"

module mac_tile (
        input  logic                clk,
        input  logic                reset,
        input  mac_data_pkg::act_t  act,
        input  mac_ctrl_pkg::inst_t inst,
        input  mac_data_pkg::psum_t psum_n,
        output mac_data_pkg::psum_t psum_s,
        output logic                psum_valid
);

        // Stored kernel weights
        mac_data_pkg::act_t  w0;
        mac_data_pkg::act_t  w1;

        // Selects the weight written by the next load cycle
        logic                load_ptr;

        // Low in the first execute cycle, high in the second
        logic                phase;

        mac_data_pkg::psum_t acc;
        mac_data_pkg::act_t  weight_sel;
        mac_data_pkg::psum_t prod;

        // The first execute cycle uses w0 and the second uses w1
        assign weight_sel = phase ? w1 : w0;

        // Both operands are zero extended before the multiply
        assign prod = mac_data_pkg::psum_t'(act) * mac_data_pkg::psum_t'(weight_sel);

        always_ff @(posedge clk) begin
                if (reset) begin
                        w0         <= '0;
                        w1         <= '0;
                        load_ptr   <= 1'b0;
                        phase      <= 1'b0;
                        psum_valid <= 1'b0;
                end else begin
                        if (inst.load) begin
                                if (load_ptr) begin
                                        w1 <= act;
                                end else begin
                                        w0 <= act;
                                end
                                load_ptr <= ~load_ptr;
                        end

                        // Valid follows the second execute cycle
                        psum_valid <= inst.execute && phase;

                        if (inst.execute) begin
                                phase <= ~phase;
                        end
                end
        end

        // Accumulate path
        always_ff @(posedge clk) begin
                if (inst.execute && !phase) begin
                        // The north psum is valid in exactly this cycle because of the row skew
                        acc <= psum_n + prod;
                end
                if (inst.execute && phase) begin
                        psum_s <= acc + prod;
                end
        end

endmodule

// File: verilog/psum_drain.sv
/* Result FIFO below the column. It has no full check, because the feeder credits
   keep the number of results in flight and stored at or below MAC_DRAIN_DEPTH */
`timescale 1ns/1ns
`include "mac_column_consts.svh"

module psum_drain (
        input  logic                clk,
        input  logic                reset,
        input  mac_data_pkg::psum_t psum,
        input  logic                psum_valid,
        input  logic                out_ack,
        output logic                out_req,
        output mac_data_pkg::psum_t out_data,
        output logic                slot_free
);

        localparam int PTR_BW = $clog2(`MAC_DRAIN_DEPTH);
        localparam int CNT_BW = $clog2(`MAC_DRAIN_DEPTH + 1);

        mac_data_pkg::psum_t fifo_mem [`MAC_DRAIN_DEPTH];
        logic [PTR_BW-1:0]   wr_ptr;
        logic [PTR_BW-1:0]   rd_ptr;
        logic [CNT_BW-1:0]   count;
        logic                pop;

        function automatic logic [PTR_BW-1:0] ptr_inc(input logic [PTR_BW-1:0] p);
                if (p == PTR_BW'(`MAC_DRAIN_DEPTH - 1)) begin
                        return '0;
                end
                return p + 1'b1;
        endfunction

        // The sink has taken the head entry
        assign pop       = out_req && out_ack;
        assign slot_free = pop;
        assign out_data  = fifo_mem[rd_ptr];

        always_ff @(posedge clk) begin
                if (psum_valid) begin
                        fifo_mem[wr_ptr] <= psum;
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        wr_ptr  <= '0;
                        rd_ptr  <= '0;
                        count   <= '0;
                        out_req <= 1'b0;
                end else begin
                        if (psum_valid) begin
                                wr_ptr <= ptr_inc(wr_ptr);
                        end
                        if (pop) begin
                                rd_ptr <= ptr_inc(rd_ptr);
                        end

                        case ({psum_valid, pop})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase

                        // A new request waits for out_ack of the last one to fall
                        // A result captured now counts already, so an empty FIFO adds no cycle
                        if (pop) begin
                                out_req <= 1'b0;
                        end else if (!out_req && !out_ack && (count != '0 || psum_valid)) begin
                                out_req <= 1'b1;
                        end
                end
        end

endmodule
